// ==== source/riscv_pkg.sv ====
// RV32I execute cluster package with sizes, operation encodings and pipeline stage structs
package riscv_pkg;

localparam int XLEN = 32;
localparam int REG_AW = 5;
localparam int CSR_AW = 12;
localparam int SHAMT_W = $clog2(XLEN);

// word-addressed local data memory
localparam int DMEM_WORDS = 16;
localparam int DMEM_AW = $clog2(DMEM_WORDS);

// no compressed instructions so the return address is always pc + 4
localparam logic [XLEN-1:0] PC_STEP = 32'd4;

typedef enum logic [1:0] {
    OPER1_RS1,
    OPER1_PC,
    OPER1_ZERO,
    OPER1_CSR_IMM
} alu_oper1_src_t;

typedef enum logic [2:0] {
    OPER2_RS2,
    OPER2_IMM,
    OPER2_PC_INC,
    OPER2_CSR,
    OPER2_ZERO
} alu_oper2_src_t;

// compare operations leave their answer in bit 0
typedef enum logic [3:0] {
    ADD, SUB,
    SEQ, SNEQ,
    SLT, SGE,
    SLTU, SGEU,
    XOR, OR, AND,
    SLL, SRL, SRA
} alu_oper_t;

typedef enum logic [1:0] {
    BNJ_NONE,
    BNJ_JAL,
    BNJ_JALR,
    BNJ_BRANCH
} bnj_oper_t;

typedef enum logic [1:0] {
    MEM_NOP,
    MEM_LW,
    MEM_SW
} mem_oper_t;

typedef enum logic [1:0] {
    NO_TRAP,
    ILLEGAL_INSTR,
    ECALL,
    BREAKPOINT
} exc_t;

// decoded instruction as it enters EX
typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   csr_rdata;
    alu_oper1_src_t    alu_oper1_src;
    alu_oper2_src_t    alu_oper2_src;
    alu_oper_t         alu_oper;
    bnj_oper_t         bnj_oper;
    logic              is_csr;
    logic              instr_valid;
    mem_oper_t         mem_oper;
    logic [CSR_AW-1:0] csr_waddr;
    logic              csr_we;
    exc_t              trap;
    logic              write_rd;
    logic [REG_AW-1:0] rd_addr;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
} id_ex_t;

// also reused for the MEM1/MEM2 register
typedef struct packed {
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   store_data;
    mem_oper_t         mem_oper;
    logic [XLEN-1:0]   pc;
    exc_t              trap;
    logic              instr_valid;
    logic              write_rd;
    logic [REG_AW-1:0] rd_addr;
} ex_mem_t;

typedef struct packed {
    logic              we;
    logic [CSR_AW-1:0] addr;
    logic [XLEN-1:0]   wdata;
} csr_wr_t;

typedef struct packed {
    logic              valid;
    logic              write_rd;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_data;
    logic [XLEN-1:0]   pc;
    exc_t              trap;
} wb_t;

// one-hot select with the nearest stage first
typedef struct packed {
    logic ex_mem1;
    logic mem1_mem2;
    logic mem2_wb;
} fwd_sel_t;

endpackage : riscv_pkg

// ==== source/forward_unit.sv ====
// forwarding unit matching EX source registers against in-flight destinations
`timescale 1ns/1ps

module forward_unit (
    input  riscv_pkg::id_ex_t                id_ex_i,
    input  riscv_pkg::ex_mem_t               ex_mem_i,
    input  logic                             mem1_mem2_write_rd_i,
    input  logic [riscv_pkg::REG_AW-1:0]     mem1_mem2_rd_addr_i,
    input  logic                             mem1_mem2_load_i,
    input  logic                             mem2_wb_write_rd_i,
    input  logic [riscv_pkg::REG_AW-1:0]     mem2_wb_rd_addr_i,
    output riscv_pkg::fwd_sel_t              fwd_rs1_o,
    output riscv_pkg::fwd_sel_t              fwd_rs2_o
);

import riscv_pkg::*;

// a stage can forward only if it writes rd with a value already known
logic ex_mem1_wr;
logic mem1_mem2_wr;
logic mem2_wb_wr;

// bit 2 is EX/MEM1, bit 0 is MEM2/WB
logic [2:0] rs1_hit;
logic [2:0] rs2_hit;

function automatic logic hit(input logic wr, input logic [REG_AW-1:0] rd,
                             input logic [REG_AW-1:0] rs);
    return wr && (rd != '0) && (rd == rs);
endfunction

function automatic fwd_sel_t encode(input logic [2:0] hits);
    fwd_sel_t sel;
    sel = '0;
    if (hits[2])
        sel.ex_mem1 = 1'b1;
    else if (hits[1])
        sel.mem1_mem2 = 1'b1;
    else if (hits[0])
        sel.mem2_wb = 1'b1;
    return sel;
endfunction

// load data is not ready before MEM2/WB
assign ex_mem1_wr = ex_mem_i.instr_valid && ex_mem_i.write_rd && (ex_mem_i.mem_oper != MEM_LW);
assign mem1_mem2_wr = mem1_mem2_write_rd_i && !mem1_mem2_load_i;
assign mem2_wb_wr = mem2_wb_write_rd_i;

assign rs1_hit = {hit(ex_mem1_wr, ex_mem_i.rd_addr, id_ex_i.rs1_addr),
                  hit(mem1_mem2_wr, mem1_mem2_rd_addr_i, id_ex_i.rs1_addr),
                  hit(mem2_wb_wr, mem2_wb_rd_addr_i, id_ex_i.rs1_addr)};

assign rs2_hit = {hit(ex_mem1_wr, ex_mem_i.rd_addr, id_ex_i.rs2_addr),
                  hit(mem1_mem2_wr, mem1_mem2_rd_addr_i, id_ex_i.rs2_addr),
                  hit(mem2_wb_wr, mem2_wb_rd_addr_i, id_ex_i.rs2_addr)};

assign fwd_rs1_o = encode(rs1_hit);
assign fwd_rs2_o = encode(rs2_hit);

endmodule : forward_unit

// ==== source/execute.sv ====
// execute stage with operand forwarding, ALU, branch/jump decision and the EX/MEM1 register
`timescale 1ns/1ps

module execute (
    input  logic                            clk_i,
    input  logic                            rstn_i,

    input  riscv_pkg::id_ex_t               id_ex_i,
    input  logic [riscv_pkg::XLEN-1:0]      rs1_data_i,
    input  logic [riscv_pkg::XLEN-1:0]      rs2_data_i,

    // forwarding selects and the data behind them
    input  riscv_pkg::fwd_sel_t             fwd_rs1_i,
    input  riscv_pkg::fwd_sel_t             fwd_rs2_i,
    input  logic [riscv_pkg::XLEN-1:0]      fwd_ex_mem1_data_i,
    input  logic [riscv_pkg::XLEN-1:0]      fwd_mem1_mem2_data_i,
    input  logic [riscv_pkg::XLEN-1:0]      fwd_mem2_wb_data_i,

    input  logic                            stall_i,
    input  logic                            flush_i,

    output riscv_pkg::ex_mem_t              ex_mem_o,
    output riscv_pkg::csr_wr_t              csr_wr_o,

    // redirect in the same cycle as the instruction
    output logic                            new_pc_en_o,
    output logic [riscv_pkg::XLEN-1:0]      branch_target_o
);

import riscv_pkg::*;

// freshest register values
logic [XLEN-1:0] rs1_data;
logic [XLEN-1:0] rs2_data;

logic [XLEN-1:0] operand1;
logic [XLEN-1:0] operand2;
logic [XLEN-1:0] alu_result;
logic [SHAMT_W-1:0] shamt;

ex_mem_t ex_mem_q;
csr_wr_t csr_wr_q;

function automatic logic [XLEN-1:0] pick(input fwd_sel_t sel,
                                         input logic [XLEN-1:0] reg_val,
                                         input logic [XLEN-1:0] ex_mem1_val,
                                         input logic [XLEN-1:0] mem1_mem2_val,
                                         input logic [XLEN-1:0] mem2_wb_val);
    logic [XLEN-1:0] val;
    val = reg_val;
    if (sel.ex_mem1)
        val = ex_mem1_val;
    else if (sel.mem1_mem2)
        val = mem1_mem2_val;
    else if (sel.mem2_wb)
        val = mem2_wb_val;
    return val;
endfunction

assign rs1_data = pick(fwd_rs1_i, rs1_data_i, fwd_ex_mem1_data_i,
                       fwd_mem1_mem2_data_i, fwd_mem2_wb_data_i);
assign rs2_data = pick(fwd_rs2_i, rs2_data_i, fwd_ex_mem1_data_i,
                       fwd_mem1_mem2_data_i, fwd_mem2_wb_data_i);

always_comb
begin : oper1_mux
    unique case (id_ex_i.alu_oper1_src)
        OPER1_RS1:     operand1 = rs1_data;
        OPER1_PC:      operand1 = id_ex_i.pc;
        OPER1_ZERO:    operand1 = '0;
        OPER1_CSR_IMM: operand1 = id_ex_i.imm;
        default:       operand1 = rs1_data;
    endcase
end

always_comb
begin : oper2_mux
    unique case (id_ex_i.alu_oper2_src)
        OPER2_RS2:    operand2 = rs2_data;
        OPER2_IMM:    operand2 = id_ex_i.imm;
        // link address for JAL/JALR
        OPER2_PC_INC: operand2 = PC_STEP;
        OPER2_CSR:    operand2 = id_ex_i.csr_rdata;
        OPER2_ZERO:   operand2 = '0;
        default:      operand2 = rs2_data;
    endcase
end

assign shamt = operand2[SHAMT_W-1:0];

always_comb
begin : alu
    unique case (id_ex_i.alu_oper)
        ADD:     alu_result = operand1 + operand2;
        SUB:     alu_result = operand1 - operand2;
        SEQ:     alu_result = XLEN'(operand1 == operand2);
        SNEQ:    alu_result = XLEN'(operand1 != operand2);
        SLT:     alu_result = XLEN'($signed(operand1) < $signed(operand2));
        SGE:     alu_result = XLEN'($signed(operand1) >= $signed(operand2));
        SLTU:    alu_result = XLEN'(operand1 < operand2);
        SGEU:    alu_result = XLEN'(operand1 >= operand2);
        XOR:     alu_result = operand1 ^ operand2;
        OR:      alu_result = operand1 | operand2;
        AND:     alu_result = operand1 & operand2;
        SLL:     alu_result = operand1 << shamt;
        SRL:     alu_result = operand1 >> shamt;
        SRA:     alu_result = $signed(operand1) >>> shamt;
        default: alu_result = operand1 + operand2;
    endcase
end

// branches use a compare op, so bit 0 is the taken flag
always_comb
begin : bnj
    new_pc_en_o = 1'b0;
    branch_target_o = id_ex_i.pc + id_ex_i.imm;
    unique case (id_ex_i.bnj_oper)
        BNJ_JAL:
            new_pc_en_o = id_ex_i.instr_valid;
        BNJ_JALR:
        begin
            new_pc_en_o = id_ex_i.instr_valid;
            branch_target_o = rs1_data + id_ex_i.imm;
        end
        BNJ_BRANCH:
            new_pc_en_o = id_ex_i.instr_valid && alu_result[0];
        default:
            new_pc_en_o = 1'b0;
    endcase
end

always_ff @(posedge clk_i, negedge rstn_i)
begin : ex_mem_reg
    if (!rstn_i)
    begin
        ex_mem_q <= '0;
        csr_wr_q <= '0;
    end
    else if (!stall_i)
    begin
        // rd value for CSR reads is the old CSR contents
        ex_mem_q.result <= id_ex_i.is_csr ? id_ex_i.csr_rdata : alu_result;
        ex_mem_q.store_data <= rs2_data;
        ex_mem_q.pc <= id_ex_i.pc;
        ex_mem_q.rd_addr <= id_ex_i.rd_addr;
        csr_wr_q.addr <= id_ex_i.csr_waddr;
        csr_wr_q.wdata <= alu_result;

        if (flush_i)
        begin
            // turn the instruction in EX into a bubble
            ex_mem_q.instr_valid <= 1'b0;
            ex_mem_q.write_rd <= 1'b0;
            ex_mem_q.mem_oper <= MEM_NOP;
            ex_mem_q.trap <= NO_TRAP;
            csr_wr_q.we <= 1'b0;
        end
        else
        begin
            ex_mem_q.instr_valid <= id_ex_i.instr_valid;
            ex_mem_q.write_rd <= id_ex_i.write_rd;
            ex_mem_q.mem_oper <= id_ex_i.mem_oper;
            ex_mem_q.trap <= id_ex_i.trap;
            csr_wr_q.we <= id_ex_i.csr_we && id_ex_i.instr_valid;
        end
    end
end

assign ex_mem_o = ex_mem_q;
assign csr_wr_o = csr_wr_q;

// data muxing above relies on forward_unit giving exclusive selects
a_fwd_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
    id_ex_i.instr_valid |-> ($onehot0(fwd_rs1_i) && $onehot0(fwd_rs2_i)))
else
    $error("execute: several forwarding selects active");

endmodule : execute

// ==== source/mem_stage.sv ====
// memory stages holding the local data memory and the MEM1/MEM2 and MEM2/WB registers
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 stall_i,
    input  riscv_pkg::ex_mem_t   ex_mem_i,
    output riscv_pkg::ex_mem_t   mem1_mem2_o,
    output riscv_pkg::wb_t       wb_o
);

import riscv_pkg::*;

logic [XLEN-1:0] dmem [DMEM_WORDS];
logic [DMEM_AW-1:0] addr;
logic store_en;

ex_mem_t mem1_mem2_q;
logic [XLEN-1:0] load_data_q;
wb_t wb_q;

// word address taken from result bits above the byte offset
assign addr = ex_mem_i.result[DMEM_AW+1:2];
assign store_en = ex_mem_i.instr_valid && (ex_mem_i.mem_oper == MEM_SW) && !stall_i;

always_ff @(posedge clk_i, negedge rstn_i)
begin : dmem_write
    if (!rstn_i)
        dmem <= '{default: '0};
    else if (store_en)
        dmem[addr] <= ex_mem_i.store_data;
end

always_ff @(posedge clk_i, negedge rstn_i)
begin : mem1_mem2_reg
    if (!rstn_i)
        mem1_mem2_q <= '0;
    else if (!stall_i)
    begin
        mem1_mem2_q <= ex_mem_i;
        // bubbles and stores never write rd
        mem1_mem2_q.write_rd <= ex_mem_i.instr_valid && ex_mem_i.write_rd
                                && (ex_mem_i.mem_oper != MEM_SW);
    end
end

// asynchronous read captured at the MEM1/MEM2 edge
always_ff @(posedge clk_i)
begin : load_capture
    if (!stall_i && (ex_mem_i.mem_oper == MEM_LW))
        load_data_q <= dmem[addr];
end

always_ff @(posedge clk_i, negedge rstn_i)
begin : mem2_wb_reg
    if (!rstn_i)
        wb_q <= '0;
    else if (!stall_i)
    begin
        wb_q.valid <= mem1_mem2_q.instr_valid;
        wb_q.write_rd <= mem1_mem2_q.write_rd;
        wb_q.rd_addr <= mem1_mem2_q.rd_addr;
        wb_q.rd_data <= (mem1_mem2_q.mem_oper == MEM_LW) ? load_data_q : mem1_mem2_q.result;
        wb_q.pc <= mem1_mem2_q.pc;
        wb_q.trap <= mem1_mem2_q.trap;
    end
end

assign mem1_mem2_o = mem1_mem2_q;
assign wb_o = wb_q;

// faulting instructions never reach memory
a_mem_no_trap: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (ex_mem_i.instr_valid && (ex_mem_i.mem_oper != MEM_NOP)) |-> (ex_mem_i.trap == NO_TRAP))
else
    $error("mem_stage: memory access with trap %0d", ex_mem_i.trap);

endmodule : mem_stage

// ==== source/ex_cluster.sv ====
// execute cluster top level joining execute, forwarding unit and the memory stages
`timescale 1ns/1ps

module ex_cluster (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  riscv_pkg::id_ex_t             id_ex_i,
    input  logic [riscv_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [riscv_pkg::XLEN-1:0]    rs2_data_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    output logic                          new_pc_en_o,
    output logic [riscv_pkg::XLEN-1:0]    branch_target_o,
    output riscv_pkg::csr_wr_t            csr_wr_o,
    output riscv_pkg::wb_t                wb_o
);

import riscv_pkg::*;

ex_mem_t ex_mem;
ex_mem_t mem1_mem2;
fwd_sel_t fwd_rs1;
fwd_sel_t fwd_rs2;
logic mem1_mem2_load;

assign mem1_mem2_load = (mem1_mem2.mem_oper == MEM_LW);

execute execute_inst (
    .clk_i                (clk_i),
    .rstn_i               (rstn_i),
    .id_ex_i              (id_ex_i),
    .rs1_data_i           (rs1_data_i),
    .rs2_data_i           (rs2_data_i),
    .fwd_rs1_i            (fwd_rs1),
    .fwd_rs2_i            (fwd_rs2),
    .fwd_ex_mem1_data_i   (ex_mem.result),
    .fwd_mem1_mem2_data_i (mem1_mem2.result),
    .fwd_mem2_wb_data_i   (wb_o.rd_data),
    .stall_i              (stall_i),
    .flush_i              (flush_i),
    .ex_mem_o             (ex_mem),
    .csr_wr_o             (csr_wr_o),
    .new_pc_en_o          (new_pc_en_o),
    .branch_target_o      (branch_target_o)
);

forward_unit forward_unit_inst (
    .id_ex_i              (id_ex_i),
    .ex_mem_i             (ex_mem),
    .mem1_mem2_write_rd_i (mem1_mem2.write_rd),
    .mem1_mem2_rd_addr_i  (mem1_mem2.rd_addr),
    .mem1_mem2_load_i     (mem1_mem2_load),
    .mem2_wb_write_rd_i   (wb_o.write_rd),
    .mem2_wb_rd_addr_i    (wb_o.rd_addr),
    .fwd_rs1_o            (fwd_rs1),
    .fwd_rs2_o            (fwd_rs2)
);

mem_stage mem_stage_inst (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .stall_i     (stall_i),
    .ex_mem_i    (ex_mem),
    .mem1_mem2_o (mem1_mem2),
    .wb_o        (wb_o)
);

endmodule : ex_cluster

// ==== testbench/ex_cluster_tb.sv ====
// execute cluster testbench checking a random instruction stream against a reference model
`timescale 1ns/1ps

module ex_cluster_tb;

import riscv_pkg::*;

localparam int CLK_PERIOD = 10;
localparam int RESET_CYCLES = 10;
localparam int NUM_CYCLES = 2000;
localparam int DRAIN_CYCLES = 4;
localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;
localparam int VW = 128;
localparam logic [31:0] SEED = 32'h696af670;

logic clk_i;
logic rstn_i;
id_ex_t id_ex_i;
logic [XLEN-1:0] rs1_data_i;
logic [XLEN-1:0] rs2_data_i;
logic stall_i;
logic flush_i;
logic new_pc_en_o;
logic [XLEN-1:0] branch_target_o;
csr_wr_t csr_wr_o;
wb_t wb_o;

// reference model state
logic [XLEN-1:0] arch_rf [32];
logic [XLEN-1:0] commit_rf [32];
logic [XLEN-1:0] arch_mem [DMEM_WORDS];
wb_t inflight [$];
wb_t next_entry;
wb_t wb_prev;
wb_t retiring;
csr_wr_t next_csr;
csr_wr_t exp_csr;
logic exp_pc_en;
logic [XLEN-1:0] exp_target;
logic [XLEN-1:0] store_data;
logic [DMEM_AW-1:0] store_idx;
logic [REG_AW-1:0] load_rd [2];
logic holding;
id_ex_t instr;

ex_cluster ex_cluster_inst (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .id_ex_i         (id_ex_i),
    .rs1_data_i      (rs1_data_i),
    .rs2_data_i      (rs2_data_i),
    .stall_i         (stall_i),
    .flush_i         (flush_i),
    .new_pc_en_o     (new_pc_en_o),
    .branch_target_o (branch_target_o),
    .csr_wr_o        (csr_wr_o),
    .wb_o            (wb_o)
);

always #(CLK_PERIOD / 2) clk_i = ~clk_i;

task automatic fail_value(input string name, input logic [VW-1:0] exp_val,
                          input logic [VW-1:0] got_val);
    $display("error: time %0t, %s expected %0h, got %0h", $time, name, exp_val, got_val);
    $display("tests failed");
    $fatal(1, "stopping at the first mismatch");
endtask

function automatic logic [XLEN-1:0] alu_model(input alu_oper_t op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        ADD:     return a + b;
        SUB:     return a - b;
        SEQ:     return {{(XLEN-1){1'b0}}, a == b};
        SNEQ:    return {{(XLEN-1){1'b0}}, a != b};
        SLT:     return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        SGE:     return {{(XLEN-1){1'b0}}, $signed(a) >= $signed(b)};
        SLTU:    return {{(XLEN-1){1'b0}}, a < b};
        SGEU:    return {{(XLEN-1){1'b0}}, a >= b};
        XOR:     return a ^ b;
        OR:      return a | b;
        AND:     return a & b;
        SLL:     return a << sh;
        SRL:     return a >> sh;
        SRA:     return $signed(a) >>> sh;
        default: return '0;
    endcase
endfunction

// small register range so that forwarding happens often
task automatic gen_instr(input logic drain, output id_ex_t ins);
    int kind;
    ins = '0;
    if (drain)
        return;
    kind = $urandom_range(9, 0);
    ins.instr_valid = 1'b1;
    ins.pc = $urandom() & 32'hffff_fffc;
    ins.imm = $urandom();
    ins.csr_rdata = $urandom();
    ins.rd_addr = REG_AW'($urandom_range(7, 0));
    ins.rs1_addr = REG_AW'($urandom_range(7, 0));
    ins.rs2_addr = REG_AW'($urandom_range(7, 0));
    ins.write_rd = 1'b1;
    ins.alu_oper1_src = alu_oper1_src_t'($urandom_range(3, 0));
    ins.alu_oper2_src = alu_oper2_src_t'($urandom_range(4, 0));
    ins.alu_oper = alu_oper_t'($urandom_range(13, 0));
    case (kind)
        4:
        begin
            ins.is_csr = 1'b1;
            ins.csr_we = 1'($urandom_range(1, 0));
            ins.csr_waddr = CSR_AW'($urandom());
        end
        5, 6:
        begin
            ins.mem_oper = (kind == 5) ? MEM_LW : MEM_SW;
            ins.write_rd = (kind == 5);
            ins.alu_oper1_src = OPER1_RS1;
            ins.alu_oper2_src = OPER2_IMM;
            ins.alu_oper = ADD;
            ins.imm = $urandom_range(63, 0);
            // absolute address now and then to hit the same word again
            if ($urandom_range(1, 0) == 0)
                ins.rs1_addr = '0;
        end
        7, 8:
        begin
            ins.bnj_oper = (kind == 7) ? BNJ_JAL : BNJ_JALR;
            ins.alu_oper1_src = OPER1_PC;
            ins.alu_oper2_src = OPER2_PC_INC;
            ins.alu_oper = ADD;
        end
        9:
        begin
            ins.bnj_oper = BNJ_BRANCH;
            ins.alu_oper1_src = OPER1_RS1;
            ins.alu_oper2_src = OPER2_RS2;
            ins.alu_oper = alu_oper_t'($urandom_range(7, 2));
            ins.write_rd = 1'b0;
        end
        default:
            if ($urandom_range(7, 0) == 0)
                ins.trap = exc_t'($urandom_range(3, 1));
    endcase
    // load result not usable in the next two slots
    if ((ins.rs1_addr != '0) && ((ins.rs1_addr == load_rd[0]) || (ins.rs1_addr == load_rd[1])))
        ins.rs1_addr = '0;
    if ((ins.rs2_addr != '0) && ((ins.rs2_addr == load_rd[0]) || (ins.rs2_addr == load_rd[1])))
        ins.rs2_addr = '0;
endtask

// expected results from the architectural state before this instruction
task automatic eval_instr(input id_ex_t ins);
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_val;
    rs1_val = arch_rf[ins.rs1_addr];
    rs2_val = arch_rf[ins.rs2_addr];
    case (ins.alu_oper1_src)
        OPER1_RS1:  op_a = rs1_val;
        OPER1_PC:   op_a = ins.pc;
        OPER1_ZERO: op_a = '0;
        default:    op_a = ins.imm;
    endcase
    case (ins.alu_oper2_src)
        OPER2_RS2:    op_b = rs2_val;
        OPER2_IMM:    op_b = ins.imm;
        OPER2_PC_INC: op_b = 32'd4;
        OPER2_CSR:    op_b = ins.csr_rdata;
        default:      op_b = '0;
    endcase
    alu_val = alu_model(ins.alu_oper, op_a, op_b);
    next_entry = '0;
    next_entry.valid = ins.instr_valid;
    next_entry.write_rd = ins.instr_valid && ins.write_rd && (ins.mem_oper != MEM_SW);
    next_entry.rd_addr = ins.rd_addr;
    next_entry.pc = ins.pc;
    next_entry.trap = ins.trap;
    if (ins.mem_oper == MEM_LW)
        next_entry.rd_data = arch_mem[alu_val[5:2]];
    else if (ins.is_csr)
        next_entry.rd_data = ins.csr_rdata;
    else
        next_entry.rd_data = alu_val;
    next_csr.we = ins.instr_valid && ins.csr_we;
    next_csr.addr = ins.csr_waddr;
    next_csr.wdata = alu_val;
    exp_pc_en = ins.instr_valid && ((ins.bnj_oper == BNJ_JAL) || (ins.bnj_oper == BNJ_JALR)
                || ((ins.bnj_oper == BNJ_BRANCH) && alu_val[0]));
    exp_target = (ins.bnj_oper == BNJ_JALR) ? rs1_val + ins.imm : ins.pc + ins.imm;
    store_data = rs2_val;
    store_idx = alu_val[5:2];
endtask

task automatic drive_cycle(input logic drain);
    logic stall;
    logic flush;
    if (!holding)
        gen_instr(drain, instr);
    eval_instr(instr);
    stall = drain ? 1'b0 : ($urandom_range(9, 0) == 0);
    flush = drain ? 1'b0 : ($urandom_range(9, 0) == 0);
    id_ex_i = instr;
    rs1_data_i = commit_rf[instr.rs1_addr];
    rs2_data_i = commit_rf[instr.rs2_addr];
    stall_i = stall;
    flush_i = flush;
    if (!stall)
    begin
        if (!flush && next_entry.write_rd && (instr.rd_addr != '0))
            arch_rf[instr.rd_addr] = next_entry.rd_data;
        if (!flush && instr.instr_valid && (instr.mem_oper == MEM_SW))
            arch_mem[store_idx] = store_data;
        load_rd[1] = load_rd[0];
        load_rd[0] = (!flush && (instr.mem_oper == MEM_LW)) ? instr.rd_addr : '0;
    end
    holding = stall;
endtask

task automatic check_redirect();
    assert (new_pc_en_o == exp_pc_en)
    else
        fail_value("new_pc_en_o", VW'(exp_pc_en), VW'(new_pc_en_o));
    if (exp_pc_en)
        assert (branch_target_o == exp_target)
        else
            fail_value("branch_target_o", VW'(exp_target), VW'(branch_target_o));
endtask

// called just after a rising edge, before new inputs are driven
task automatic advance_and_check();
    wb_t exp;
    if (!stall_i)
    begin
        void'(inflight.pop_front());
        inflight.push_back(flush_i ? wb_t'('0) : next_entry);
        exp_csr = next_csr;
        if (flush_i)
            exp_csr.we = 1'b0;
    end
    else
        assert (wb_o == wb_prev)
        else
            fail_value("wb_o", VW'(wb_prev), VW'(wb_o));
    exp = inflight[0];
    assert (wb_o.valid == exp.valid)
    else
        fail_value("wb_o.valid", VW'(exp.valid), VW'(wb_o.valid));
    assert (wb_o.write_rd == exp.write_rd)
    else
        fail_value("wb_o.write_rd", VW'(exp.write_rd), VW'(wb_o.write_rd));
    if (exp.write_rd)
    begin
        assert (wb_o.rd_addr == exp.rd_addr)
        else
            fail_value("wb_o.rd_addr", VW'(exp.rd_addr), VW'(wb_o.rd_addr));
        assert (wb_o.rd_data == exp.rd_data)
        else
            fail_value("wb_o.rd_data", VW'(exp.rd_data), VW'(wb_o.rd_data));
    end
    if (exp.valid)
    begin
        assert (wb_o.pc == exp.pc)
        else
            fail_value("wb_o.pc", VW'(exp.pc), VW'(wb_o.pc));
        assert (wb_o.trap == exp.trap)
        else
            fail_value("wb_o.trap", VW'(exp.trap), VW'(wb_o.trap));
    end
    assert (csr_wr_o.we == exp_csr.we)
    else
        fail_value("csr_wr_o.we", VW'(exp_csr.we), VW'(csr_wr_o.we));
    if (exp_csr.we)
    begin
        assert (csr_wr_o.addr == exp_csr.addr)
        else
            fail_value("csr_wr_o.addr", VW'(exp_csr.addr), VW'(csr_wr_o.addr));
        assert (csr_wr_o.wdata == exp_csr.wdata)
        else
            fail_value("csr_wr_o.wdata", VW'(exp_csr.wdata), VW'(csr_wr_o.wdata));
    end
    // the entry leaving MEM2/WB at this edge is written to the register file
    if (!stall_i && retiring.write_rd && (retiring.rd_addr != '0))
        commit_rf[retiring.rd_addr] = retiring.rd_data;
    retiring = exp;
    wb_prev = wb_o;
endtask

initial
begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: the run went on longer than the test length allows");
    $display("tests failed");
    $fatal(1, "watchdog expired");
end

initial
begin : main
    int cyc;
    clk_i = 1'b0;
    rstn_i = 1'b0;
    id_ex_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    stall_i = 1'b0;
    flush_i = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < 32; i++)
    begin
        arch_rf[i] = '0;
        commit_rf[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++)
        arch_mem[i] = '0;
    load_rd[0] = '0;
    load_rd[1] = '0;
    holding = 1'b0;
    wb_prev = '0;
    retiring = '0;
    exp_csr = '0;
    // three empty pipeline registers after reset
    repeat (3)
        inflight.push_back(wb_t'('0));

    repeat (RESET_CYCLES)
        @(posedge clk_i);
    #1;
    rstn_i = 1'b1;

    for (cyc = 0; cyc < NUM_CYCLES; cyc++)
    begin
        drive_cycle(cyc >= NUM_CYCLES - DRAIN_CYCLES);
        #2;
        check_redirect();
        @(posedge clk_i);
        #1;
        advance_and_check();
    end

    $display("all tests passed");
    $finish;
end

endmodule : ex_cluster_tb

// ==== list.f ====
source/riscv_pkg.sv
source/forward_unit.sv
source/execute.sv
source/mem_stage.sv
source/ex_cluster.sv
testbench/ex_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute cluster testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module ex_cluster_tb \
    -o ex_cluster_sim --Mdir obj_dir \
    && ./obj_dir/ex_cluster_sim | tee sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
